// File: files.f
mul_pkg.sv
partial_product_stage.sv
column_sum_stage.sv
group_merge_stage.sv
final_merge_stage.sv
lowmul_top.sv
tb_checker.sv
tb_lowmul.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing -f files.f --top-module tb_lowmul \
        && ./obj_dir/Vtb_lowmul | tee /dev/stderr | grep -q "^No errors$" \
        && echo "Simulation PASSED" \
        || { echo "Simulation FAILED"; exit 1; }

// File: tb_lowmul.sv
// Testbench top that walks the stimulus table through the low-half multiplier DUT
`timescale 1ns/1ns

module tb_lowmul;

        localparam int N_DIRECTED = 10;
        localparam int N_RANDOM   = 32;
        localparam int N_TESTS    = N_DIRECTED + N_RANDOM;
        localparam int CLK_NS     = 4;
        localparam int LIMIT_NS   = (N_TESTS + 5) * 8 * CLK_NS;  // Room for random stalls

        localparam mul_pkg::operand_t PATTERN =
                256'h0123456789abcdef_fedcba9876543210_a5a5a5a5c3c3c3c3_0f1e2d3c4b5a6978;

        logic              clk;
        logic              rst_n;
        logic              in_valid;
        logic              in_ready;
        mul_pkg::mul_req_t in_req;
        logic              out_valid;
        logic              out_ready;
        mul_pkg::operand_t out_result;
        logic [127:0]      cur_name;   // Row name for the checker's report

        // ------------------------------
        // Stimulus table
        // ------------------------------
        string             row_name [N_TESTS];
        mul_pkg::operand_t row_x    [N_TESTS];
        mul_pkg::operand_t row_y    [N_TESTS];
        bit                row_bp   [N_TESTS];  // Random out_ready and input gaps

        int                seed = 32'h45db;
        int                pass_cnt;
        int                fail_cnt;
        int                result_cnt;
        int                error_cnt;

        lowmul_top lowmul_top_inst (
                .clk, .rst_n,
                .in_valid, .in_ready, .in_req,
                .out_valid, .out_ready, .out_result
        );

        tb_checker checker_inst (
                .clk, .rst_n,
                .in_valid, .in_ready, .in_req,
                .in_name   (cur_name),
                .out_valid, .out_ready, .out_result,
                .pass_cnt, .fail_cnt, .result_cnt, .error_cnt
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_NS / 2) clk = ~clk;
        end

        // Watchdog
        initial begin
                #(LIMIT_NS);
                $display("Timeout after %0d ns, %0d of %0d results still missing",
                         LIMIT_NS, N_TESTS - result_cnt, N_TESTS);
                $display("Errors found");
                $finish;
        end

        // Name as space-padded text of up to 16 chars
        function automatic logic [127:0] pack_name(input string s);
                logic [127:0] b;
                b = {16{8'h20}};
                for (int i = 0; i < s.len() && i < 16; i++) begin
                        b[127-8*i -: 8] = s[i];
                end
                return b;
        endfunction

        function automatic logic random_bit();
                int r;
                r = $random(seed);
                return r[0];
        endfunction

        function automatic mul_pkg::operand_t random_word();
                mul_pkg::operand_t w;
                for (int i = 0; i < 8; i++) begin
                        w[32*i +: 32] = $random(seed);
                end
                return w;
        endfunction

        task automatic set_row(input int k, input string name, input mul_pkg::operand_t x,
                               input mul_pkg::operand_t y, input bit bp);
                row_name[k] = name;
                row_x[k]    = x;
                row_y[k]    = y;
                row_bp[k]   = bp;
        endtask

        task automatic build_table();
                mul_pkg::operand_t one;
                mul_pkg::operand_t x_r;
                mul_pkg::operand_t y_r;
                int                bit_pos  [6];
                bit                bit_in_y [6];
                one      = mul_pkg::operand_t'(1);
                bit_pos  = '{15, 16, 23, 24, 240, 255};   // Limb edges of x and y
                bit_in_y = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};  // 15 and 16 are y edges only
                // Directed corners back to back with out_ready high
                set_row(0, "zero_x_val", '0, PATTERN, 1'b0);
                set_row(1, "one_x_val", one, PATTERN, 1'b0);
                set_row(2, "all_ones_sq", '1, '1, 1'b0);      // Wraps to 1
                for (int b = 0; b < 6; b++) begin
                        if (bit_in_y[b]) begin
                                set_row(3 + b, $sformatf("bit_%0d", bit_pos[b]),
                                        PATTERN, one << bit_pos[b], 1'b0);
                        end else begin
                                set_row(3 + b, $sformatf("bit_%0d", bit_pos[b]),
                                        one << bit_pos[b], PATTERN, 1'b0);
                        end
                end
                set_row(9, "pp_max_stalled", '1, '1, 1'b1);   // Every limb product maximal
                for (int r = 0; r < N_RANDOM; r++) begin
                        x_r = random_word();
                        y_r = random_word();
                        set_row(N_DIRECTED + r, $sformatf("rand_%0d", r), x_r, y_r, 1'b1);
                end
        endtask

        // ------------------------------
        // Reset, drive loop and wrap-up
        // ------------------------------
        initial begin
                logic accepted;
                in_valid  = 1'b0;
                in_req    = '0;
                out_ready = 1'b1;
                cur_name  = '0;
                rst_n     = 1'b0;
                build_table();
                repeat (3) @(posedge clk);
                #1 rst_n = 1'b1;
                @(posedge clk);                 // Checker samples idle state here
                #1;
                for (int k = 0; k < N_TESTS; k++) begin
                        // Occasional bubble ahead of stalled rows
                        if (row_bp[k] && random_bit()) begin
                                in_valid  = 1'b0;
                                out_ready = random_bit();
                                @(posedge clk);
                                #1;
                        end
                        in_valid = 1'b1;
                        in_req.x = row_x[k];
                        in_req.y = row_y[k];
                        cur_name = pack_name(row_name[k]);
                        accepted = 1'b0;
                        while (!accepted) begin
                                out_ready = row_bp[k] ? random_bit() : 1'b1;
                                #(CLK_NS - 2);          // 1 ns before the edge
                                accepted = in_ready;
                                @(posedge clk);
                                #1;
                        end
                end
                in_valid  = 1'b0;
                out_ready = 1'b1;                       // Drain
                wait (result_cnt == N_TESTS);
                repeat (4) @(posedge clk);              // Any extra output gets flagged
                $display("Totals: %0d passed, %0d failed, %0d results, %0d errors",
                         pass_cnt, fail_cnt, result_cnt, error_cnt);
                if (error_cnt == 0 && fail_cnt == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule

// File: tb_checker.sv
// Testbench checker that predicts (x * y) mod 2^256 per accepted request and checks each result
`timescale 1ns/1ns

module tb_checker (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              in_valid,
        input  logic              in_ready,
        input  mul_pkg::mul_req_t in_req,
        input  logic [127:0]      in_name,     // Table name of the row on offer
        input  logic              out_valid,
        input  logic              out_ready,
        input  mul_pkg::operand_t out_result,
        output int                pass_cnt,
        output int                fail_cnt,
        output int                result_cnt,
        output int                error_cnt
);

        localparam int LATENCY = 5;  // Input transfer to output transfer without stalls

        // Requests in flight with the oldest first
        mul_pkg::operand_t q_x     [$];
        mul_pkg::operand_t q_y     [$];
        logic [127:0]      q_name  [$];
        int                q_cycle [$];   // Cycle of the input transfer
        int                q_stall [$];   // Stall count at the input transfer

        int                cycle      = 0;
        int                stall_cnt  = 0;  // Edges with out_ready low
        int                n_pass     = 0;
        int                n_fail     = 0;
        int                n_result   = 0;
        int                n_error    = 0;
        logic              reset_seen = 1'b0;
        logic              hold_on    = 1'b0;  // Output was stalled at the last edge
        mul_pkg::operand_t hold_val   = '0;

        assign pass_cnt   = n_pass;
        assign fail_cnt   = n_fail;
        assign result_cnt = n_result;
        assign error_cnt  = n_error;

        // Reference product in 512 bits before keeping the low half
        function automatic mul_pkg::operand_t low_product(input mul_pkg::operand_t x,
                                                          input mul_pkg::operand_t y);
                logic [511:0] wide;
                wide = {256'b0, x} * {256'b0, y};
                return wide[255:0];
        endfunction

        task automatic flag_result(input mul_pkg::operand_t exp_v,
                                   input mul_pkg::operand_t got_v);
                $display("CHECK FAILED at %0t ns: out_result expected %0h, got %0h",
                         $time, exp_v, got_v);
                n_error++;
        endtask

        // Idle state right after reset
        task automatic compare_idle_state();
                logic ok;
                ok = 1'b1;
                if (out_valid !== 1'b0) begin
                        $display("CHECK FAILED at %0t ns: out_valid expected 0, got %b",
                                 $time, out_valid);
                        ok = 1'b0;
                        n_error++;
                end
                if (in_ready !== 1'b1) begin
                        $display("CHECK FAILED at %0t ns: in_ready expected 1, got %b",
                                 $time, in_ready);
                        ok = 1'b0;
                        n_error++;
                end
                if (ok) n_pass++;
                else    n_fail++;
                $display("%s reset_state", ok ? "pass" : "FAIL");
        endtask

        // Stalled output must hold its value
        task automatic watch_stall_hold();
                if (hold_on && out_valid !== 1'b1) begin
                        $display("Error at %0t ns: out_valid dropped while out_ready was low",
                                 $time);
                        n_error++;
                end else if (hold_on && out_result !== hold_val) begin
                        flag_result(hold_val, out_result);
                end
                hold_on  = out_valid && !out_ready;
                hold_val = out_result;
        endtask

        // Pop the oldest request and score the result against it
        task automatic score_output();
                mul_pkg::operand_t expect_v;
                logic [127:0]      name;
                int                lat;
                int                stall_at_in;
                logic              ok;
                n_result++;
                if (q_x.size() == 0) begin
                        $display("Error at %0t ns: result came out with no request in flight",
                                 $time);
                        n_error++;
                end else begin
                        ok          = 1'b1;
                        expect_v    = low_product(q_x.pop_front(), q_y.pop_front());
                        name        = q_name.pop_front();
                        lat         = cycle - q_cycle.pop_front();
                        stall_at_in = q_stall.pop_front();
                        if (out_result !== expect_v) begin
                                flag_result(expect_v, out_result);
                                ok = 1'b0;
                        end
                        // Latency fixed only when nothing stalled in between
                        if (stall_at_in == stall_cnt && lat != LATENCY) begin
                                $display("CHECK FAILED at %0t ns: latency expected %0d, got %0d",
                                         $time, LATENCY, lat);
                                n_error++;
                                ok = 1'b0;
                        end
                        if (ok) n_pass++;
                        else    n_fail++;
                        $display("%s %s", ok ? "pass" : "FAIL", name);
                end
        endtask

        // ------------------------------
        // Sampling at each rising edge
        // ------------------------------
        always @(posedge clk) begin
                if (rst_n) begin
                        cycle++;
                        if (!reset_seen) begin
                                reset_seen = 1'b1;
                                compare_idle_state();
                        end
                        watch_stall_hold();
                        if (out_valid && out_ready) begin
                                score_output();
                        end

                        if (!out_ready) stall_cnt++;

                        // Queue the operands of each input transfer
                        if (in_valid && in_ready) begin
                                q_x.push_back(in_req.x);
                                q_y.push_back(in_req.y);
                                q_name.push_back(in_name);
                                q_cycle.push_back(cycle);
                                q_stall.push_back(stall_cnt);
                        end
                end
        end

endmodule

// File: lowmul_top.sv
// Top of the pipelined multiplier returning (x * y) mod 2^256, five stages with valid/ready
`timescale 1ns/1ns

module lowmul_top (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              in_valid,
        output logic              in_ready,
        input  mul_pkg::mul_req_t in_req,
        output logic              out_valid,
        input  logic              out_ready,
        output mul_pkg::operand_t out_result
);

        // Links between stages
        logic                 pp_valid,  pp_ready;
        mul_pkg::pp_set_t     pp_set;
        logic                 col_valid, col_ready;
        mul_pkg::col_sums_t   col_sums;
        logic                 grp_valid, grp_ready;
        mul_pkg::group_sums_t grp_sums;

        // ------------------------------
        // Stage chain
        // ------------------------------
        partial_product_stage partial_product_stage_inst (
                .clk, .rst_n,
                .in_valid (in_valid),  .in_ready (in_ready),  .in_req (in_req),
                .out_valid(pp_valid),  .out_ready(pp_ready),  .out_pp (pp_set)
        );

        column_sum_stage column_sum_stage_inst (
                .clk, .rst_n,
                .in_valid (pp_valid),  .in_ready (pp_ready),  .in_pp   (pp_set),
                .out_valid(col_valid), .out_ready(col_ready), .out_cols(col_sums)
        );

        group_merge_stage group_merge_stage_inst (
                .clk, .rst_n,
                .in_valid (col_valid), .in_ready (col_ready), .in_cols   (col_sums),
                .out_valid(grp_valid), .out_ready(grp_ready), .out_groups(grp_sums)
        );

        final_merge_stage final_merge_stage_inst (
                .clk, .rst_n,
                .in_valid (grp_valid), .in_ready (grp_ready), .in_groups (grp_sums),
                .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
        );

endmodule

// File: final_merge_stage.sv
// Stages 3 and 4 of the low-half multiplier, folds the group sums into the 256-bit result
`timescale 1ns/1ns

module final_merge_stage (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 in_valid,
        output logic                 in_ready,
        input  mul_pkg::group_sums_t in_groups,
        output logic                 out_valid,
        input  logic                 out_ready,
        output mul_pkg::operand_t    out_result
);

        localparam int HI_BASE = 160;  // Bit offset of group 2

        typedef struct packed {
                mul_pkg::operand_t lo;  // Groups 0 and 1, base 0
                mul_pkg::operand_t hi;  // Groups 2 to 4, base 160
        } half_sums_t;

        half_sums_t halves;
        logic       halves_valid;
        logic       halves_ready;

        assign halves_ready = !out_valid || out_ready;
        assign in_ready     = !halves_valid || halves_ready;

        // ------------------------------
        // Stage 3, two half sums
        // ------------------------------
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        halves_valid <= 1'b0;
                        halves       <= '0;
                end else if (in_ready) begin
                        halves_valid <= in_valid;
                        if (in_valid) begin
                                halves.lo <= in_groups[0] + (in_groups[1] << 112);
                                halves.hi <= in_groups[2] + (in_groups[3] << 40)
                                           + (in_groups[4] << 72);
                        end
                end
        end

        // Stage 4, final fold, top carries wrap away
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid  <= 1'b0;
                        out_result <= '0;
                end else if (halves_ready) begin
                        out_valid <= halves_valid;
                        if (halves_valid) begin
                                out_result <= halves.lo + (halves.hi << HI_BASE);
                        end
                end
        end

endmodule

// File: group_merge_stage.sv
// Stage 2 of the low-half multiplier, merges the 19 column sums into 5 group sums
`timescale 1ns/1ns

module group_merge_stage (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 in_valid,
        output logic                 in_ready,
        input  mul_pkg::col_sums_t   in_cols,
        output logic                 out_valid,
        input  logic                 out_ready,
        output mul_pkg::group_sums_t out_groups
);

        mul_pkg::group_sums_t group_next;

        assign in_ready = !out_valid || out_ready;

        // Shifts are column base minus group base, carries above bit 255 dropped
        always_comb begin
                group_next[0] = in_cols[0] + (in_cols[1] << 40)
                              + (in_cols[2] << 72) + (in_cols[3] << 96);   // Base 0
                group_next[1] = in_cols[4] + (in_cols[5] << 16)
                              + (in_cols[6] << 32) + (in_cols[7] << 40);   // Base 112
                group_next[2] = in_cols[8] + (in_cols[9] << 8)
                              + (in_cols[10] << 24) + (in_cols[11] << 32); // Base 160
                group_next[3] = in_cols[12] + (in_cols[13] << 8)
                              + (in_cols[14] << 16) + (in_cols[15] << 24); // Base 200
                group_next[4] = in_cols[16] + (in_cols[17] << 8)
                              + (in_cols[18] << 16);                        // Base 232
        end

        // ------------------------------
        // Output register
        // ------------------------------
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid  <= 1'b0;
                        out_groups <= '0;
                end else if (in_ready) begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                out_groups <= group_next;
                        end
                end
        end

endmodule

// File: column_sum_stage.sv
// Stage 1 of the low-half multiplier, adds the limb products into 19 offset-aligned column sums
`timescale 1ns/1ns

module column_sum_stage (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                in_valid,
        output logic                in_ready,
        input  mul_pkg::pp_set_t    in_pp,
        output logic                out_valid,
        input  logic                out_ready,
        output mul_pkg::col_sums_t  out_cols
);

        mul_pkg::operand_t  p [mul_pkg::X_LIMBS][mul_pkg::Y_LIMBS];  // Products by limb pair
        mul_pkg::col_sums_t col_next;

        assign in_ready = !out_valid || out_ready;

        // Unpack slots into pair indexing, unused pairs stay zero
        always_comb begin
                p = '{default: '0};
                for (int s = 0; s < mul_pkg::PP_COUNT; s++) begin
                        p[mul_pkg::PP_X_IDX[s]][mul_pkg::PP_Y_IDX[s]] =
                                mul_pkg::operand_t'(in_pp[s]);
                end
        end

        always_comb begin
                // ------------------------------
                // Low columns, bases 0..128
                // ------------------------------
                col_next[0]  = p[0][0] + (p[0][1] << 16)
                             + ((p[1][0] + (p[0][2] << 8)) << 24);           // Base 0
                col_next[1]  = p[1][1] + ((p[0][3] + p[2][0]) << 8)
                             + ((p[1][2] + ((p[0][4] + p[2][1]) << 8)) << 16); // Base 40
                col_next[2]  = (p[1][3] + p[3][0]) + ((p[2][2] + p[0][5]) << 8)
                             + ((p[1][4] + p[3][1]) << 16);                   // Base 72
                col_next[3]  = (p[0][6] + p[2][3] + p[4][0])
                             + ((p[1][5] + p[3][2]) << 8);                    // Base 96
                col_next[4]  = (p[0][7] + p[2][4] + p[4][1])
                             + ((p[1][6] + p[3][3] + p[5][0]) << 8);          // Base 112
                col_next[5]  = (p[0][8] + p[2][5] + p[4][2])
                             + ((p[1][7] + p[3][4] + p[5][1]) << 8);          // Base 128

                // ------------------------------
                // Middle columns, bases 144..192
                // ------------------------------
                col_next[6]  = p[0][9] + p[2][6] + p[4][3] + p[6][0];        // Base 144
                col_next[7]  = p[1][8] + p[3][5] + p[5][2];                  // Base 152
                col_next[8]  = p[0][10] + p[2][7] + p[4][4] + p[6][1]
                             + ((p[1][9] + p[3][6]) << 8);                    // Base 160
                col_next[9]  = p[5][3] + p[7][0]
                             + ((p[0][11] + p[2][8] + p[4][5] + p[6][2]) << 8); // Base 168
                col_next[10] = p[1][10] + p[3][7] + p[5][4] + p[7][1];       // Base 184
                col_next[11] = p[0][12] + p[2][9] + p[4][6] + p[6][3] + p[8][0];

                // ------------------------------
                // High columns, bases 200..248
                // ------------------------------
                col_next[12] = p[1][11] + p[3][8] + p[5][5] + p[7][2];       // Base 200
                col_next[13] = p[0][13] + p[2][10] + p[4][7] + p[6][4] + p[8][1];
                col_next[14] = p[1][12] + p[3][9] + p[5][6] + p[7][3] + p[9][0];
                col_next[15] = p[2][11] + p[0][14] + p[4][8] + p[6][5] + p[8][2];
                col_next[16] = p[1][13] + p[3][10] + p[5][7] + p[7][4] + p[9][1];
                col_next[17] = p[0][15] + p[2][12] + p[4][9] + p[6][6] + p[8][3]
                             + p[10][0];                                      // Base 240
                col_next[18] = p[1][14] + p[3][11] + p[5][8] + p[7][5] + p[9][2];
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        out_cols  <= '0;
                end else if (in_ready) begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                out_cols <= col_next;
                        end
                end
        end

endmodule

// File: partial_product_stage.sv
// Stage 0 of the low-half multiplier, slices operands into limbs and registers the 96 products
`timescale 1ns/1ns

module partial_product_stage (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              in_valid,
        output logic              in_ready,
        input  mul_pkg::mul_req_t in_req,
        output logic              out_valid,
        input  logic              out_ready,
        output mul_pkg::pp_set_t  out_pp
);

        logic [mul_pkg::X_LIMB_W-1:0] x_limb [mul_pkg::X_LIMBS];
        logic [mul_pkg::Y_LIMB_W-1:0] y_limb [mul_pkg::Y_LIMBS];
        mul_pkg::pp_set_t             pp_next;

        // Accept when empty or when the item leaves this cycle
        assign in_ready = !out_valid || out_ready;

        // ------------------------------
        // Limb slicing
        // ------------------------------
        always_comb begin
                for (int i = 0; i < mul_pkg::X_LIMBS - 1; i++) begin
                        x_limb[i] = in_req.x[i*mul_pkg::X_LIMB_W +: mul_pkg::X_LIMB_W];
                end
                // Top limb only 16 bits wide, zero-extend
                x_limb[mul_pkg::X_LIMBS-1] = mul_pkg::X_LIMB_W'(
                        in_req.x[(mul_pkg::X_LIMBS-1)*mul_pkg::X_LIMB_W +: mul_pkg::X_TOP_W]);
                for (int j = 0; j < mul_pkg::Y_LIMBS; j++) begin
                        y_limb[j] = in_req.y[j*mul_pkg::Y_LIMB_W +: mul_pkg::Y_LIMB_W];
                end
        end

        // ------------------------------
        // Limb products, slot order
        // ------------------------------
        always_comb begin
                for (int s = 0; s < mul_pkg::PP_COUNT; s++) begin
                        pp_next[s] = x_limb[mul_pkg::PP_X_IDX[s]]
                                   * y_limb[mul_pkg::PP_Y_IDX[s]];  // 24 x 16 -> 40 bits
                end
        end

        // Output register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        out_pp    <= '0;
                end else if (in_ready) begin
                        out_valid <= in_valid;  // Bubble when nothing offered
                        if (in_valid) begin
                                out_pp <= pp_next;
                        end
                end
        end

endmodule

// File: mul_pkg.sv
// Widths, limb geometry, partial-product slot tables and bus types shared by the multiplier stages
package mul_pkg;

        // ------------------------------
        // Operand and limb geometry
        // ------------------------------
        localparam int OPERAND_W   = 256;                 // Operands and result
        localparam int X_LIMB_W    = 24;
        localparam int X_TOP_W     = 16;                  // Top x limb, bits 255:240
        localparam int X_LIMBS     = 11;
        localparam int Y_LIMB_W    = 16;
        localparam int Y_LIMBS     = 16;
        localparam int PP_W        = X_LIMB_W + Y_LIMB_W; // 40-bit limb product
        localparam int PP_COUNT    = 96;                  // Pairs with offset below 256
        localparam int COL_COUNT   = 19;                  // Stage 1 column sums
        localparam int GROUP_COUNT = 5;                   // Stage 2 group sums
        localparam int PP_IDX_W    = 4;                   // Fits limb index 0..15

        typedef logic [PP_COUNT-1:0][PP_IDX_W-1:0] pp_idx_tab_t;

        // Row-major walk by x limb then y limb
        // Pairs at offset 256 or more add nothing to the low half and get no slot
        function automatic pp_idx_tab_t build_pp_idx(input bit want_x);
                pp_idx_tab_t tab;
                int          s;
                tab = '0;
                s   = 0;
                for (int i = 0; i < X_LIMBS; i++) begin
                        for (int j = 0; j < Y_LIMBS; j++) begin
                                if (i * X_LIMB_W + j * Y_LIMB_W < OPERAND_W) begin
                                        tab[s] = want_x ? PP_IDX_W'(i) : PP_IDX_W'(j);
                                        s++;
                                end
                        end
                end
                return tab;
        endfunction

        // Slot s holds x limb PP_X_IDX[s] times y limb PP_Y_IDX[s]
        localparam pp_idx_tab_t PP_X_IDX = build_pp_idx(1'b1);
        localparam pp_idx_tab_t PP_Y_IDX = build_pp_idx(1'b0);

        // ------------------------------
        // Stage bus types
        // ------------------------------
        typedef logic [OPERAND_W-1:0] operand_t;

        typedef struct packed {
                operand_t x;
                operand_t y;
        } mul_req_t;

        typedef logic [PP_COUNT-1:0][PP_W-1:0] pp_set_t;    // Limb products, slot order
        typedef operand_t [COL_COUNT-1:0]      col_sums_t;  // Offset-aligned column sums
        typedef operand_t [GROUP_COUNT-1:0]    group_sums_t;

endpackage
